// ==== verification/eth_reflector_vectors.txt ====
# columns: length(dec) drop dst_mac src_mac ethertype payload_fill, one frame per line
# payload byte j (from 14 on) is (fill + j) ^ (j >> 8); drop 1 means no reply
# ip to the device, arp broadcast
64 0 001999cf95fa 02a0c9112233 0800 3c
60 0 ffffffffffff 02a0c9445566 0806 a1
# filtered frames, each followed by one that must come back
64 1 001999cf95fb 02a0c9112233 0800 10
46 0 001999cf95fa 02a0c9112233 0800 11
64 1 001999cf95fa 02a0c9112233 86dd 22
64 1 001999cf95fa 02a0c9112233 0801 23
50 0 ffffffffffff 02a0c9112233 0806 24
14 1 001999cf95fa 02a0c9112233 0800 00
10 1 001999cf95fa 02a0c9112233 0800 00
15 0 001999cf95fa 0a0b0c0d0e0f 0800 7f
600 1 ffffffffffff 02a0c9778899 0806 5e
517 1 ffffffffffff 02a0c9778899 0806 c4
516 0 ffffffffffff 02a0c9778899 0806 c3
1533 1 001999cf95fa 02a0c9abcdef 0800 92
1532 0 001999cf95fa 02a0c9abcdef 0800 91
64 1 7f1999cf95fa 02a0c9112233 0800 33
42 0 001999cf95fa 02a0c9445566 0806 08
# sequence with random length fifo gaps
128 0 ffffffffffff 00000000beef 0800 e0
72 0 001999cf95fa 0200deadbeef 0800 01
15 0 ffffffffffff 0200deadbeef 0806 02
200 0 001999cf95fa 021122334455 0800 03
33 1 001999cf95fa 021122334455 0000 04
99 0 001999cf95fa 021122334455 0806 05
64 0 ffffffffffff 02a0c9010203 0800 06
17 0 001999cf95fa 02a0c9010203 0800 07
255 0 001999cf95fa 02a0c9040506 0806 08
256 0 001999cf95fa 02a0c9040506 0800 09
300 0 ffffffffffff 02a0c9070809 0800 0a
20 1 000000000000 02a0c9070809 0800 0b
61 0 001999cf95fa 02a0c90a0b0c 0806 0c
90 0 001999cf95fa 02a0c90a0b0c 0800 0d
16 0 ffffffffffff 02a0c90d0e0f 0806 0e
180 0 001999cf95fa 02a0c90d0e0f 0800 0f
64 0 001999cf95fa 02a0c9112233 0800 fe

// ==== eth_reflector_top.f ====
common/eth_reflector_pkg.sv
rtl/rx_frame_reader.sv
rtl/frame_buffer.sv
tx/tx_header_writer.sv
tx/tx_frame_sender.sv
rtl/eth_reflector_top.sv
verification/tb_eth_reflector.sv

// ==== Bender.yml ====
package:
  name: eth_reflector

sources:
  # shared package first
  - common/eth_reflector_pkg.sv
  # rx side and buffer
  - rtl/rx_frame_reader.sv
  - rtl/frame_buffer.sv
  # tx side
  - tx/tx_header_writer.sv
  - tx/tx_frame_sender.sv
  # top level
  - rtl/eth_reflector_top.sv
  # testbench
  - target: test
    files:
      - verification/tb_eth_reflector.sv

// ==== verification/tb_eth_reflector.sv ====
`timescale 1ns/100ps

module tb_eth_reflector;

  localparam eth_reflector_pkg::mac_addr_t DEVICE_MAC = 48'h001999cf95fa;
  localparam int GAP_BITS  = 4;                      // length fifo gap drawn per entry
  localparam int GAP_MAX   = (1 << GAP_BITS) - 1;
  localparam int RESET_CYC = 10;
  localparam int DRAIN_CYC = 20;                     // quiet time after the last frame

  logic                          clk_i;
  logic                          reset_n;
  logic                          rx_len_fifo_empty_i;
  eth_reflector_pkg::frame_len_t rx_len_fifo_data_i;
  logic [7:0]                    rx_data_fifo_data_i;
  logic                          rx_len_fifo_rd_o;
  logic                          rx_data_fifo_rd_o;
  logic [7:0]                    tx_data_fifo_data_o;
  logic                          tx_data_fifo_wr_o;
  eth_reflector_pkg::frame_len_t tx_len_fifo_data_o;
  logic                          tx_len_fifo_wr_o;

  logic [7:0]                    rx_bytes [$];       // all input frames back to back
  int                            frame_len [$];
  int                            frame_off [$];      // first byte of each frame in rx_bytes
  int                            exp_frame [$];      // input frames that must come back
  int                            len_ptr;            // next length entry
  int                            data_ptr;           // next data byte
  int                            gap_cnt;            // cycles the length fifo stays hidden
  logic                          len_empty_q;        // empty flag the DUT saw at the last edge
  logic [31:0]                   lfsr_q;
  int                            out_frames;         // replies seen so far
  eth_reflector_pkg::frame_len_t out_bytes;          // data writes in the current reply
  int                            cycles;
  int                            cycle_limit;

  eth_reflector_top #(.DEVICE_MAC(DEVICE_MAC)) dut0 (
    .clk_i               (clk_i),
    .reset_n             (reset_n),
    .rx_len_fifo_empty_i (rx_len_fifo_empty_i),
    .rx_len_fifo_data_i  (rx_len_fifo_data_i),
    .rx_data_fifo_data_i (rx_data_fifo_data_i),
    .rx_len_fifo_rd_o    (rx_len_fifo_rd_o),
    .rx_data_fifo_rd_o   (rx_data_fifo_rd_o),
    .tx_data_fifo_data_o (tx_data_fifo_data_o),
    .tx_data_fifo_wr_o   (tx_data_fifo_wr_o),
    .tx_len_fifo_data_o  (tx_len_fifo_data_o),
    .tx_len_fifo_wr_o    (tx_len_fifo_wr_o)
  );

  always #2 clk_i = ~clk_i;                          // 4 ns period

  // ==========================================================================
  // checks
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      report_failure($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_len(input string name, input eth_reflector_pkg::frame_len_t exp,
                           input eth_reflector_pkg::frame_len_t act);
    if (exp !== act) begin
      report_failure($sformatf("Error %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic int draw_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v      = (v << 1) | lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  // payload pattern, uses the whole byte index
  function automatic logic [7:0] payload_byte(input logic [7:0] fill, input int j);
    return (fill + j[7:0]) ^ j[15:8];
  endfunction

  // reply byte j of input frame f: sender MAC, device MAC, type and payload as received
  function automatic logic [7:0] reply_byte(input int f, input int j);
    int off;
    off = frame_off[f];
    if (j < 6) begin
      return rx_bytes[off + 6 + j];
    end else if (j < 12) begin
      return DEVICE_MAC[8*(11-j) +: 8];
    end
    return rx_bytes[off + j];
  endfunction

  // ==========================================================================
  // vector file, one frame per line
  task automatic load_vectors();
    int          fd;
    string       line;
    int          len;
    int          drop;
    int          n_items;
    logic [47:0] dst;
    logic [47:0] src;
    logic [15:0] etype;
    logic [7:0]  fill;
    logic [111:0] hdr;
    fd = $fopen("verification/eth_reflector_vectors.txt", "r");
    if (fd == 0) begin
      report_failure("could not open the vector file verification/eth_reflector_vectors.txt");
    end
    cycle_limit = RESET_CYC + DRAIN_CYC;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 3 || line[0] == "#") begin
        continue;                                    // blank or comment line
      end
      n_items = $sscanf(line, "%d %d %h %h %h %h", len, drop, dst, src, etype, fill);
      if (n_items != 6) begin
        report_failure({"malformed line in the vector file: ", line});
      end
      hdr = {dst, src, etype};
      frame_off.push_back(rx_bytes.size());
      frame_len.push_back(len);
      for (int j = 0; j < len; j++) begin
        rx_bytes.push_back((j < 14) ? hdr[8*(13-j) +: 8] : payload_byte(fill, j));
      end
      if (drop == 0) begin
        exp_frame.push_back(frame_len.size() - 1);
      end
      cycle_limit += 3 * len + 40 + GAP_MAX;         // read, header, send and gap
    end
    $fclose(fd);
    if (frame_len.size() == 0) begin
      report_failure("the vector file holds no frames");
    end
  endtask

  // ==========================================================================
  // rx fifo model, data fifo shows its head byte, a read pulse pops it
  always @(posedge clk_i) begin
    if (reset_n) begin
      if (rx_len_fifo_rd_o) begin
        if (len_empty_q || (len_ptr >= frame_len.size())) begin
          report_failure("length FIFO was read while empty");
        end
        rx_len_fifo_data_i <= eth_reflector_pkg::frame_len_t'(frame_len[len_ptr]);
        len_ptr++;
        gap_cnt = draw_bits(GAP_BITS);               // hide the next entry for a while
      end else if (gap_cnt > 0) begin
        gap_cnt--;
      end
      if (rx_data_fifo_rd_o) begin
        if (data_ptr >= rx_bytes.size()) begin
          report_failure("data FIFO was read past the last byte");
        end
        data_ptr++;
      end
    end
    len_empty_q         <= rx_len_fifo_empty_i;
    rx_len_fifo_empty_i <= !reset_n || (len_ptr >= frame_len.size()) || (gap_cnt != 0);
    rx_data_fifo_data_i <= (data_ptr < rx_bytes.size()) ? rx_bytes[data_ptr] : 8'h00;
  end

  // tx capture against the reflected input frames
  always @(posedge clk_i) begin
    int f;
    if (reset_n && (tx_data_fifo_wr_o || tx_len_fifo_wr_o)) begin
      if (out_frames >= exp_frame.size()) begin
        report_failure("DUT wrote to a TX FIFO with no frame expected");
      end
      f = exp_frame[out_frames];
      if (tx_data_fifo_wr_o) begin
        if (out_bytes >= frame_len[f]) begin
          report_failure($sformatf("frame %0d got more data writes than its length", f));
        end
        check_byte($sformatf("frame %0d byte %0d", f, out_bytes), reply_byte(f, out_bytes),
                   tx_data_fifo_data_o);
        out_bytes++;
      end
      if (tx_len_fifo_wr_o) begin
        check_len($sformatf("frame %0d data writes", f), frame_len[f], out_bytes);
        check_len($sformatf("frame %0d length entry", f), frame_len[f], tx_len_fifo_data_o);
        out_frames++;
        out_bytes = '0;
      end
    end
  end

  // run limit from the frame lengths
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      report_failure($sformatf("timeout after %0d cycles, %0d of %0d replies seen",
                               cycles, out_frames, exp_frame.size()));
    end
  end

  // ==========================================================================
  initial begin
    clk_i               = 1'b0;
    reset_n             = 1'b0;
    rx_len_fifo_empty_i = 1'b1;
    rx_len_fifo_data_i  = '0;
    rx_data_fifo_data_i = '0;
    len_empty_q         = 1'b1;
    lfsr_q              = 32'h5e687545;
    len_ptr             = 0;
    data_ptr            = 0;
    gap_cnt             = 0;
    out_frames          = 0;
    out_bytes           = '0;
    cycles              = 0;
    cycle_limit         = 1000;
    load_vectors();
    repeat (RESET_CYC) @(posedge clk_i);
    reset_n <= 1'b1;
    // every length taken, every byte pulled, every reply seen
    while (len_ptr < frame_len.size() || data_ptr < rx_bytes.size() ||
           out_frames < exp_frame.size()) begin
      @(negedge clk_i);
    end
    repeat (DRAIN_CYC) @(negedge clk_i);             // catch stray output
    if (out_frames == exp_frame.size()) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      report_failure($sformatf("Error frame count: expected %0d, actual %0d",
                               exp_frame.size(), out_frames));
    end
  end

endmodule

// ==== rtl/eth_reflector_top.sv ====
`timescale 1ns/100ps

module eth_reflector_top #(
  parameter eth_reflector_pkg::mac_addr_t DEVICE_MAC = 48'h001999cf95fa
) (
  input  logic                          clk_i,
  input  logic                          reset_n,
  // rx fifo side
  input  logic                          rx_len_fifo_empty_i,
  input  eth_reflector_pkg::frame_len_t rx_len_fifo_data_i,
  input  logic [7:0]                    rx_data_fifo_data_i,
  output logic                          rx_len_fifo_rd_o,
  output logic                          rx_data_fifo_rd_o,
  // tx fifo side
  output logic [7:0]                    tx_data_fifo_data_o,
  output logic                          tx_data_fifo_wr_o,
  output eth_reflector_pkg::frame_len_t tx_len_fifo_data_o,
  output logic                          tx_len_fifo_wr_o
);

  eth_reflector_pkg::frame_desc_t rx_desc;          // reader -> header writer
  eth_reflector_pkg::frame_desc_t snd_desc;         // header writer -> sender
  logic                           hdr_req;
  logic                           hdr_ack;
  logic                           snd_req;
  logic                           snd_ack;
  eth_reflector_pkg::buf_wr_t     payload_wr;
  eth_reflector_pkg::buf_wr_t     hdr_wr;
  eth_reflector_pkg::buf_addr_t   rd_addr;
  logic [7:0]                     rd_data;

  rx_frame_reader #(.DEVICE_MAC(DEVICE_MAC)) u_rx_reader (
    .clk_i               (clk_i),
    .reset_n             (reset_n),
    .rx_len_fifo_empty_i (rx_len_fifo_empty_i),
    .rx_len_fifo_data_i  (rx_len_fifo_data_i),
    .rx_data_fifo_data_i (rx_data_fifo_data_i),
    .rx_len_fifo_rd_o    (rx_len_fifo_rd_o),
    .rx_data_fifo_rd_o   (rx_data_fifo_rd_o),
    .payload_wr_o        (payload_wr),
    .desc_o              (rx_desc),
    .hdr_req_o           (hdr_req),
    .hdr_ack_i           (hdr_ack)
  );

  frame_buffer u_tx_buffer (
    .clk_i        (clk_i),
    .hdr_wr_i     (hdr_wr),
    .payload_wr_i (payload_wr),
    .rd_addr_i    (rd_addr),
    .rd_data_o    (rd_data)
  );

  tx_header_writer #(.DEVICE_MAC(DEVICE_MAC)) u_hdr_writer (
    .clk_i      (clk_i),
    .reset_n    (reset_n),
    .desc_i     (rx_desc),
    .hdr_req_i  (hdr_req),
    .hdr_ack_o  (hdr_ack),
    .hdr_wr_o   (hdr_wr),
    .snd_desc_o (snd_desc),
    .snd_req_o  (snd_req),
    .snd_ack_i  (snd_ack)
  );

  tx_frame_sender u_tx_sender (
    .clk_i               (clk_i),
    .reset_n             (reset_n),
    .desc_i              (snd_desc),
    .snd_req_i           (snd_req),
    .snd_ack_o           (snd_ack),
    .rd_addr_o           (rd_addr),
    .rd_data_i           (rd_data),
    .tx_data_fifo_data_o (tx_data_fifo_data_o),
    .tx_data_fifo_wr_o   (tx_data_fifo_wr_o),
    .tx_len_fifo_data_o  (tx_len_fifo_data_o),
    .tx_len_fifo_wr_o    (tx_len_fifo_wr_o)
  );

endmodule

// ==== tx/tx_frame_sender.sv ====
`timescale 1ns/100ps

module tx_frame_sender (
  input  logic                           clk_i,
  input  logic                           reset_n,
  input  eth_reflector_pkg::frame_desc_t desc_i,
  input  logic                           snd_req_i,
  output logic                           snd_ack_o,
  output eth_reflector_pkg::buf_addr_t   rd_addr_o,
  input  logic [7:0]                     rd_data_i,
  output logic [7:0]                     tx_data_fifo_data_o,
  output logic                           tx_data_fifo_wr_o,
  output eth_reflector_pkg::frame_len_t  tx_len_fifo_data_o,
  output logic                           tx_len_fifo_wr_o
);

  typedef enum logic [1:0] {
    TX_IDLE,                                         // wait for a send request
    TX_PRIME,                                        // first read in flight
    TX_STREAM,                                       // one byte per cycle
    TX_DONE                                          // write length, acknowledge
  } tx_state_e;

  tx_state_e                     state_q;
  eth_reflector_pkg::frame_len_t cnt_q;              // bytes left to push

  // ==========================================================================
  // tx control FSM
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      state_q           <= TX_IDLE;
      cnt_q             <= '0;
      snd_ack_o         <= 1'b0;
      tx_data_fifo_wr_o <= 1'b0;
      tx_len_fifo_wr_o  <= 1'b0;
    end else begin
      tx_data_fifo_wr_o <= 1'b0;
      tx_len_fifo_wr_o  <= 1'b0;
      if (snd_ack_o && !snd_req_i) begin
        snd_ack_o <= 1'b0;
      end
      case (state_q)
        TX_IDLE: begin
          if (snd_req_i && !snd_ack_o) begin
            cnt_q   <= desc_i.len;
            state_q <= TX_PRIME;
          end
        end
        TX_PRIME: state_q <= TX_STREAM;
        TX_STREAM: begin
          tx_data_fifo_wr_o <= 1'b1;                 // rd_data_i is the previous address
          cnt_q             <= cnt_q - 16'd1;
          if (cnt_q == 16'd1) begin
            state_q <= TX_DONE;
          end
        end
        TX_DONE: begin
          tx_len_fifo_wr_o <= 1'b1;                  // length after the last data byte
          snd_ack_o        <= 1'b1;
          state_q          <= TX_IDLE;
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // read address and output data
  always_ff @(posedge clk_i) begin
    if (state_q == TX_IDLE) begin
      rd_addr_o <= eth_reflector_pkg::region_base(desc_i.eth_type);
    end else begin
      rd_addr_o <= rd_addr_o + 1'b1;                 // arp region ends at the top
    end
    if (state_q == TX_STREAM) begin
      tx_data_fifo_data_o <= rd_data_i;
    end
    if (state_q == TX_DONE) begin
      tx_len_fifo_data_o <= desc_i.len;
    end
  end

  // one length entry per request, next one only after the handshake closes
  a_one_len_write: assert property (@(posedge clk_i) disable iff (!reset_n)
    tx_len_fifo_wr_o |=> (!tx_len_fifo_wr_o until !snd_ack_o));

endmodule

// ==== tx/tx_header_writer.sv ====
`timescale 1ns/100ps

module tx_header_writer #(
  parameter eth_reflector_pkg::mac_addr_t DEVICE_MAC = 48'h001999cf95fa
) (
  input  logic                           clk_i,
  input  logic                           reset_n,
  input  eth_reflector_pkg::frame_desc_t desc_i,
  input  logic                           hdr_req_i,
  output logic                           hdr_ack_o,
  output eth_reflector_pkg::buf_wr_t     hdr_wr_o,
  output eth_reflector_pkg::frame_desc_t snd_desc_o,
  output logic                           snd_req_o,
  input  logic                           snd_ack_i
);

  localparam logic [3:0] STEP_SEND = 4'd15;          // handshake with the sender

  logic [3:0]   step_q;                              // 0 idle, 1..14 header bytes
  logic [3:0]   byte_idx;
  logic [111:0] hdr_sr_q;                            // outgoing header, msb first

  assign byte_idx   = step_q - 4'd1;
  assign snd_desc_o = desc_i;                        // stable until our ack falls

  assign hdr_wr_o = '{
    en:   (step_q != 4'd0) && (step_q != STEP_SEND),
    addr: eth_reflector_pkg::region_base(desc_i.eth_type) +
          eth_reflector_pkg::buf_addr_t'(byte_idx),
    data: hdr_sr_q[111:104]
  };

  // ==========================================================================
  // header sequencer
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      step_q    <= 4'd0;
      snd_req_o <= 1'b0;
      hdr_ack_o <= 1'b0;
    end else begin
      if (hdr_ack_o && !hdr_req_i) begin
        hdr_ack_o <= 1'b0;                           // reader closed the handshake
      end
      case (step_q)
        4'd0: begin
          if (hdr_req_i && !hdr_ack_o) begin
            step_q <= 4'd1;
          end
        end
        STEP_SEND: begin
          if (snd_req_o && snd_ack_i) begin
            snd_req_o <= 1'b0;
          end else if (!snd_req_o && !snd_ack_i) begin
            hdr_ack_o <= 1'b1;                       // frame is out, release reader
            step_q    <= 4'd0;
          end
        end
        default: begin
          if (step_q == 4'(eth_reflector_pkg::ETH_HDR_LEN)) begin
            step_q    <= STEP_SEND;
            snd_req_o <= 1'b1;
          end else begin
            step_q <= step_q + 4'd1;
          end
        end
      endcase
    end
  end

  // reply header: sender's MAC, our MAC, type unchanged
  always_ff @(posedge clk_i) begin
    if (step_q == 4'd0) begin
      hdr_sr_q <= {desc_i.dst_mac, DEVICE_MAC, desc_i.eth_type};
    end else begin
      hdr_sr_q <= hdr_sr_q << 8;
    end
  end

endmodule

// ==== rtl/frame_buffer.sv ====
`timescale 1ns/100ps

module frame_buffer (
  input  logic                         clk_i,
  input  eth_reflector_pkg::buf_wr_t   hdr_wr_i,      // header writer port
  input  eth_reflector_pkg::buf_wr_t   payload_wr_i,  // rx payload port
  input  eth_reflector_pkg::buf_addr_t rd_addr_i,
  output logic [7:0]                   rd_data_o
);

  logic [7:0] mem_q [eth_reflector_pkg::BUF_DEPTH];  // ip and arp regions

  // ==========================================================================
  // writes, header port first
  always_ff @(posedge clk_i) begin
    if (hdr_wr_i.en) begin
      mem_q[hdr_wr_i.addr] <= hdr_wr_i.data;
    end else if (payload_wr_i.en) begin
      mem_q[payload_wr_i.addr] <= payload_wr_i.data;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk_i) begin
    rd_data_o <= mem_q[rd_addr_i];
  end

  // reader and header writer work on the buffer in turn
  a_single_writer: assert property (@(posedge clk_i)
    !(hdr_wr_i.en && payload_wr_i.en));

endmodule

// ==== rtl/rx_frame_reader.sv ====
`timescale 1ns/100ps

module rx_frame_reader #(
  parameter eth_reflector_pkg::mac_addr_t DEVICE_MAC = 48'h001999cf95fa
) (
  input  logic                           clk_i,
  input  logic                           reset_n,
  input  logic                           rx_len_fifo_empty_i,
  input  eth_reflector_pkg::frame_len_t  rx_len_fifo_data_i,
  input  logic [7:0]                     rx_data_fifo_data_i,
  output logic                           rx_len_fifo_rd_o,
  output logic                           rx_data_fifo_rd_o,
  output eth_reflector_pkg::buf_wr_t     payload_wr_o,
  output eth_reflector_pkg::frame_desc_t desc_o,
  output logic                           hdr_req_o,
  input  logic                           hdr_ack_i
);

  typedef enum logic [2:0] {
    RX_IDLE,                                         // wait for a length entry
    RX_WAIT_LEN,                                     // length fifo latency
    RX_LOAD,                                         // length valid, load counters
    RX_PULL,                                         // strobe the data fifo
    RX_WAIT_BYTE                                     // byte on the bus, consume it
  } rx_state_e;

  rx_state_e                     state_q;
  eth_reflector_pkg::frame_len_t rem_q;              // bytes still to pull
  eth_reflector_pkg::frame_len_t idx_q;              // index of the current byte
  eth_reflector_pkg::frame_len_t len_q;              // length of the current frame
  logic [111:0]                  hdr_q;              // dst MAC, src MAC, type
  eth_reflector_pkg::eth_type_e  rx_type;
  eth_reflector_pkg::frame_len_t region_max;
  logic                          dst_ok;
  logic                          type_ok;
  logic                          len_ok;
  logic                          frame_ok;
  logic                          last_byte;

  // ==========================================================================
  // frame filter, valid once the header has been shifted in
  assign rx_type    = eth_reflector_pkg::eth_type_e'(hdr_q[15:0]);
  assign dst_ok     = (hdr_q[111:64] == DEVICE_MAC) || (hdr_q[111:64] == '1); // own or bcast
  assign type_ok    = (rx_type == eth_reflector_pkg::ETH_TYPE_IP) ||
                      (rx_type == eth_reflector_pkg::ETH_TYPE_ARP);
  assign region_max = (rx_type == eth_reflector_pkg::ETH_TYPE_ARP) ?
                      eth_reflector_pkg::ARP_REGION_MAX : eth_reflector_pkg::IP_REGION_MAX;
  assign len_ok     = (len_q >= eth_reflector_pkg::MIN_FRAME_LEN) && (len_q <= region_max);
  assign frame_ok   = dst_ok && type_ok && len_ok;
  assign last_byte  = (state_q == RX_WAIT_BYTE) && (rem_q == 16'd1);

  // payload lands at region base + byte index, header slots left for the writer
  assign payload_wr_o = '{
    en:   (state_q == RX_WAIT_BYTE) && (idx_q >= eth_reflector_pkg::ETH_HDR_LEN) && frame_ok,
    addr: eth_reflector_pkg::region_base(rx_type) +
          idx_q[eth_reflector_pkg::BUF_ADDR_W-1:0],
    data: rx_data_fifo_data_i
  };

  // ==========================================================================
  // fifo control FSM
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      state_q           <= RX_IDLE;
      rem_q             <= '0;
      idx_q             <= '0;
      rx_len_fifo_rd_o  <= 1'b0;
      rx_data_fifo_rd_o <= 1'b0;
      hdr_req_o         <= 1'b0;
    end else begin
      rx_len_fifo_rd_o  <= 1'b0;                     // one-cycle strobes
      rx_data_fifo_rd_o <= 1'b0;
      if (last_byte && frame_ok) begin
        hdr_req_o <= 1'b1;                           // hand frame to the tx side
      end else if (hdr_ack_i) begin
        hdr_req_o <= 1'b0;
      end
      case (state_q)
        RX_IDLE: begin
          // buffer is busy until the previous handshake has fully closed
          if (!rx_len_fifo_empty_i && !hdr_req_o && !hdr_ack_i) begin
            rx_len_fifo_rd_o <= 1'b1;
            state_q          <= RX_WAIT_LEN;
          end
        end
        RX_WAIT_LEN: state_q <= RX_LOAD;
        RX_LOAD: begin
          rem_q   <= rx_len_fifo_data_i;
          idx_q   <= '0;
          state_q <= (rx_len_fifo_data_i == '0) ? RX_IDLE : RX_PULL;
        end
        RX_PULL: begin
          rx_data_fifo_rd_o <= 1'b1;
          state_q           <= RX_WAIT_BYTE;
        end
        RX_WAIT_BYTE: begin
          rem_q   <= rem_q - 16'd1;
          idx_q   <= idx_q + 16'd1;
          state_q <= last_byte ? RX_IDLE : RX_PULL;
        end
        default: state_q <= RX_IDLE;
      endcase
    end
  end

  // header capture and descriptor
  always_ff @(posedge clk_i) begin
    if (state_q == RX_LOAD) begin
      len_q <= rx_len_fifo_data_i;
    end
    if ((state_q == RX_WAIT_BYTE) && (idx_q < eth_reflector_pkg::ETH_HDR_LEN)) begin
      hdr_q <= {hdr_q[103:0], rx_data_fifo_data_i};  // shift in header bytes
    end
    if (last_byte && frame_ok) begin
      desc_o <= '{eth_type: rx_type, len: len_q, dst_mac: hdr_q[63:16]}; // reply to sender
    end
  end

  // request and descriptor hold until the header writer answers
  a_req_held: assert property (@(posedge clk_i) disable iff (!reset_n)
    hdr_req_o && !hdr_ack_i |=> hdr_req_o && $stable(desc_o));

endmodule

// ==== common/eth_reflector_pkg.sv ====
package eth_reflector_pkg;

  // ==========================================================================
  // buffer geometry
  localparam int BUF_ADDR_W = 11;                    // transmit buffer address width
  localparam int BUF_DEPTH  = 2048;                  // buffer size in bytes

  typedef logic [47:0]           mac_addr_t;         // ethernet MAC address
  typedef logic [15:0]           frame_len_t;        // frame length in bytes
  typedef logic [BUF_ADDR_W-1:0] buf_addr_t;         // buffer byte address

  localparam buf_addr_t  ARP_REGION_BASE = 11'd1532; // IP region starts at 0
  localparam frame_len_t IP_REGION_MAX   = 16'd1532; // largest frame in IP region
  localparam frame_len_t ARP_REGION_MAX  = 16'd516;  // largest frame in ARP region
  localparam frame_len_t ETH_HDR_LEN     = 16'd14;   // dst MAC, src MAC, type
  localparam frame_len_t MIN_FRAME_LEN   = 16'd15;   // header plus one payload byte

  // ==========================================================================
  // accepted ethertypes
  typedef enum logic [15:0] {
    ETH_TYPE_IP  = 16'h0800,
    ETH_TYPE_ARP = 16'h0806
  } eth_type_e;

  // one byte write into the transmit buffer
  typedef struct packed {
    logic      en;                                   // write strobe
    buf_addr_t addr;
    logic [7:0] data;
  } buf_wr_t;

  // frame passed between the stages
  typedef struct packed {
    eth_type_e  eth_type;                            // selects the buffer region
    frame_len_t len;                                 // whole frame, header included
    mac_addr_t  dst_mac;                             // MAC the reply goes to
  } frame_desc_t;

  // start of the buffer region used by a frame type
  function automatic buf_addr_t region_base(eth_type_e eth_type);
    return (eth_type == ETH_TYPE_ARP) ? ARP_REGION_BASE : '0;
  endfunction

endpackage
